//--- test/ps2_kbd_stim.txt
// Scan byte to send, then the expected hold-mode key vector after it (both hex)
// Vector bits 0 to 9 are left right up down w a s d space enter
1D 010
F0 010
1D 000
E0 000
74 002
E0 002
F0 002
74 000
F0 000
15 000
1C 020
1B 060
1C 060
29 160
E0 160
75 164
F0 164
1C 144
5A 344
E0 344
6B 345
23 3C5
E0 3C5
72 3CD
E0 3CD
F0 3CD
72 3C5

//--- verilog.f
src/ps2_kbd_pkg.sv
src/ps2_line_sync.sv
src/ps2_frame_receiver.sv
src/scan_code_decoder.sv
src/key_event_shaper.sv
src/ps2_keyboard_tracker.sv
test/tb_ps2_keyboard_tracker.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= tb_ps2_keyboard_tracker
RTL_TOP   ?= ps2_keyboard_tracker
BUILD_DIR ?= build
PASS_MSG  ?= STATUS: PASS
VFLAGS    ?= --timing --assert

.PHONY: lint sim sim_hold sim_pulse run clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim: sim_hold sim_pulse

sim_hold:
	$(MAKE) run MODE=0 NAME=hold

sim_pulse:
	$(MAKE) run MODE=1 NAME=pulse

run:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
	  -Gpulse_mode=$(MODE) --Mdir $(BUILD_DIR)/$(NAME) -o sim_$(NAME)
	$(BUILD_DIR)/$(NAME)/sim_$(NAME) > $(BUILD_DIR)/$(NAME).log 2>&1 || true
	cat $(BUILD_DIR)/$(NAME).log
	grep -q "$(PASS_MSG)" $(BUILD_DIR)/$(NAME).log

clean:
	rm -rf $(BUILD_DIR)

//--- test/tb_ps2_keyboard_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ps2_keyboard_tracker
  import ps2_kbd_pkg::*;
#(
  parameter bit pulse_mode = 1'b0
);

  // One PS/2 bit is a high half and a low half of this many clocks
  localparam int half_bit_clocks = 10;
  localparam int clk_period      = 4;
  localparam int reset_cycles    = 5;
  // Wait after the stop-bit rise before looking at keys
  localparam int settle_clocks   = 20;
  localparam int max_lines       = 64;
  localparam int max_gap         = 15;
  localparam int frame_clocks    = 11 * 2 * half_bit_clocks + settle_clocks;
  localparam string stim_file    = "test/ps2_kbd_stim.txt";

  logic        clk;
  logic        reset;
  logic        ps2_clk;
  logic        ps2_dat;
  key_vec_t    keys;

  // Byte and expected vector alternate in the file
  logic [15:0] stim_mem [0:2*max_lines-1];
  int          line_count;
  logic        stim_loaded;
  int          mismatch_errors;
  int          other_errors;
  // High cycles seen per key output
  int          pulse_count [key_count];
  logic [31:0] rng_state;

  ps2_keyboard_tracker #(
    .pulse_mode (pulse_mode)
  ) UUT (
    .clk     (clk),
    .reset   (reset),
    .ps2_clk (ps2_clk),
    .ps2_dat (ps2_dat),
    .keys    (keys)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // 32-bit xorshift step
  function automatic logic [31:0] next_random(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Lands 1 ns after a rising edge where inputs change
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Data changes midway through the high half and holds across the rise
  task automatic send_bit(input logic b);
    wait_cycles(half_bit_clocks / 2);
    ps2_dat = b;
    wait_cycles(half_bit_clocks - half_bit_clocks / 2);
    ps2_clk = 1'b0;
    wait_cycles(half_bit_clocks);
    ps2_clk = 1'b1;
  endtask

  // Start, eight data bits LSB first, odd parity, stop
  task automatic send_frame(input logic [7:0] data);
    send_bit(1'b0);
    for (int i = 0; i < 8; i++)
    begin
      send_bit(data[i]);
    end
    send_bit(~^data);
    send_bit(1'b1);
  endtask

  task automatic check_keys(input key_vec_t expected);
    assert (keys == expected)
    else
    begin
      mismatch_errors++;
      $display("Mismatch at %0t: keys = %h, expected %h", $time, keys, expected);
    end
  endtask

  task automatic finish_run();
    $display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
    if ((mismatch_errors + other_errors) == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  // Mid-cycle count of output high cycles
  always @(negedge clk)
  begin
    if (reset === 1'b0)
    begin
      for (int i = 0; i < key_count; i++)
      begin
        if (keys[i])
        begin
          pulse_count[i]++;
        end
      end
    end
  end

  initial
  begin : main
    logic [7:0] code;
    key_vec_t   expected;
    key_vec_t   previous;
    int         rises [key_count];
    int         gap;
    ps2_clk         = 1'b1;
    ps2_dat         = 1'b1;
    reset           = 1'b1;
    mismatch_errors = 0;
    other_errors    = 0;
    line_count      = 0;
    stim_loaded     = 1'b0;
    rng_state       = 32'd5;
    previous        = '0;
    for (int i = 0; i < key_count; i++)
    begin
      pulse_count[i] = 0;
      rises[i]       = 0;
    end
    // Top bit set marks words the file never wrote
    for (int i = 0; i < 2 * max_lines; i++)
    begin
      stim_mem[i] = 16'h8000 | 16'(i);
    end
    $readmemh(stim_file, stim_mem);
    while ((line_count < max_lines) && !stim_mem[2 * line_count][15])
    begin
      line_count++;
    end
    stim_loaded = 1'b1;
    assert (line_count > 0)
    else
    begin
      other_errors++;
      $display("Stimulus file %s holds no usable lines", stim_file);
    end

    wait_cycles(reset_cycles);
    reset = 1'b0;
    // Nothing pressed before the first frame
    wait_cycles(2);
    check_keys('0);

    for (int n = 0; n < line_count; n++)
    begin
      code     = stim_mem[2 * n][7:0];
      expected = stim_mem[2 * n + 1][key_count-1:0];
      send_frame(code);
      wait_cycles(settle_clocks);
      if (!pulse_mode)
      begin
        check_keys(expected);
      end
      // Each press in the file is one expected pulse
      for (int i = 0; i < key_count; i++)
      begin
        if (expected[i] && !previous[i])
        begin
          rises[i]++;
        end
      end
      previous  = expected;
      rng_state = next_random(rng_state);
      gap       = 5 + int'(rng_state % 32'd11);
      wait_cycles(gap);
    end

    if (pulse_mode)
    begin
      for (int i = 0; i < key_count; i++)
      begin
        assert (pulse_count[i] == rises[i])
        else
        begin
          mismatch_errors++;
          $display("Mismatch at %0t: keys[%0d] pulse count = %0d, expected %0d",
                   $time, i, pulse_count[i], rises[i]);
        end
      end
    end
    finish_run();
  end

  initial
  begin : watchdog
    int limit_cycles;
    wait (stim_loaded);
    // Worst-case frame plus gap per line and some slack
    limit_cycles = reset_cycles + line_count * (frame_clocks + max_gap) + 200;
    repeat (limit_cycles) @(posedge clk);
    other_errors++;
    $display("Timeout: run did not finish within %0d clock cycles", limit_cycles);
    finish_run();
  end

endmodule

`default_nettype wire

//--- src/ps2_keyboard_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard_tracker
  import ps2_kbd_pkg::*;
#(
  parameter bit pulse_mode = 1'b0
)
(
  input  logic     clk,
  input  logic     reset,
  input  logic     ps2_clk,
  input  logic     ps2_dat,
  output key_vec_t keys
);

  // Synchronized line events
  logic       ps2_clk_rise;
  logic       ps2_clk_fall;
  logic       data_sample;
  // Received byte and its strobe
  scan_byte_t rx_byte;
  logic       byte_valid;
  // Pressed state per tracked key
  key_vec_t   key_down;

  ps2_line_sync u_line_sync (
    .clk          (clk),
    .reset        (reset),
    .ps2_clk      (ps2_clk),
    .ps2_dat      (ps2_dat),
    .ps2_clk_rise (ps2_clk_rise),
    .ps2_clk_fall (ps2_clk_fall),
    .data_sample  (data_sample)
  );

  ps2_frame_receiver u_frame_receiver (
    .clk          (clk),
    .reset        (reset),
    .ps2_clk_rise (ps2_clk_rise),
    .ps2_clk_fall (ps2_clk_fall),
    .data_sample  (data_sample),
    .rx_byte      (rx_byte),
    .byte_valid   (byte_valid)
  );

  scan_code_decoder u_decoder (
    .clk        (clk),
    .reset      (reset),
    .rx_byte    (rx_byte),
    .byte_valid (byte_valid),
    .key_down   (key_down)
  );

  key_event_shaper #(
    .pulse_mode (pulse_mode)
  ) u_shaper (
    .clk      (clk),
    .reset    (reset),
    .key_down (key_down),
    .keys     (keys)
  );

endmodule

`default_nettype wire

//--- src/key_event_shaper.sv
`timescale 1ns/1ps
`default_nettype none

module key_event_shaper
  import ps2_kbd_pkg::*;
#(
  // 0 for hold levels, 1 for one-cycle press pulses
  parameter bit pulse_mode = 1'b0
)
(
  input  logic     clk,
  input  logic     reset,
  input  key_vec_t key_down,
  output key_vec_t keys
);

  generate
    if (pulse_mode)
    begin : g_pulse
      // Lock follows key_down a cycle late
      key_vec_t key_lock;

      always_ff @(posedge clk)
      begin
        if (reset)
        begin
          key_lock <= '0;
        end
        else
        begin
          key_lock <= key_down;
        end
      end

      // High only in the first cycle of a press
      assign keys = key_down & ~key_lock;
    end
    else
    begin : g_hold
      // Level straight from the decoder
      assign keys = key_down;
    end
  endgenerate

endmodule

`default_nettype wire

//--- src/scan_code_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module scan_code_decoder
  import ps2_kbd_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  scan_byte_t rx_byte,
  input  logic       byte_valid,
  output key_vec_t   key_down
);

  prefix_state_t prefix_state;
  // One-hot match of the byte against the key table
  key_vec_t      code_hit;
  // Key code under this prefix means press
  logic          make_code;

  always_comb
  begin
    for (int i = 0; i < key_count; i++)
    begin
      code_hit[i] = (rx_byte == key_code_table[i]);
    end
  end

  // E0 alone is still a press, only F0 means release
  assign make_code = (prefix_state == pfx_make) || (prefix_state == pfx_ext_make);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      prefix_state <= pfx_make;
      key_down     <= '0;
    end
    else if (byte_valid)
    begin
      if (rx_byte == code_extended)
      begin
        prefix_state <= pfx_ext_make;
      end
      else if (rx_byte == code_break)
      begin
        // Break after E0 stays in the extended space
        prefix_state <= (prefix_state == pfx_make) ? pfx_break : pfx_ext_break;
      end
      else
      begin
        // Any other byte ends the sequence
        prefix_state <= pfx_make;
        // Only the matching key changes
        for (int i = 0; i < key_count; i++)
        begin
          if (code_hit[i])
          begin
            key_down[i] <= make_code;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- src/ps2_frame_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_frame_receiver
  import ps2_kbd_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       ps2_clk_rise,
  input  logic       ps2_clk_fall,
  input  logic       data_sample,
  output scan_byte_t rx_byte,
  output logic       byte_valid
);

  rx_state_t  state;
  // Counts data bits already shifted in
  logic [2:0] bit_count;
  // Data bits arrive LSB first, so shift in from the top
  scan_byte_t shift_reg;
  logic       last_data_bit;

  assign last_data_bit = (int'(bit_count) == data_bits - 1);

  // Frame FSM, advances only on PS/2 clock edges
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state      <= rx_idle;
      bit_count  <= 3'd0;
      byte_valid <= 1'b0;
      rx_byte    <= '0;
    end
    else
    begin
      // Strobe lasts a single cycle
      byte_valid <= 1'b0;

      case (state)
        rx_idle:
        begin
          // Start bit is a low data line on the rising clock
          // Falls in idle carry nothing and are ignored
          if (ps2_clk_rise && !data_sample)
          begin
            state     <= rx_data_in;
            bit_count <= 3'd0;
          end
        end

        rx_data_in:
        begin
          if (ps2_clk_rise)
          begin
            bit_count <= bit_count + 3'd1;
            if (last_data_bit)
            begin
              state <= rx_parity_in;
            end
          end
        end

        rx_parity_in:
        begin
          // Parity bit passes through unchecked
          if (ps2_clk_rise)
          begin
            state <= rx_stop_in;
          end
        end

        rx_stop_in:
        begin
          // Low line at the stop bit fall, frame was cut short
          if (ps2_clk_fall && !data_sample)
          begin
            state <= rx_idle;
          end
          else if (ps2_clk_rise)
          begin
            state      <= rx_idle;
            byte_valid <= 1'b1;
            // Byte held until the next complete frame
            rx_byte    <= shift_reg;
          end
        end

        default:
        begin
          state <= rx_idle;
        end
      endcase
    end
  end

  // Payload shifter
  always_ff @(posedge clk)
  begin
    if ((state == rx_data_in) && ps2_clk_rise)
    begin
      shift_reg <= {data_sample, shift_reg[7:1]};
    end
  end

endmodule

`default_nettype wire

//--- src/ps2_line_sync.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_line_sync (
  input  logic clk,
  input  logic reset,
  input  logic ps2_clk,
  input  logic ps2_dat,
  output logic ps2_clk_rise,
  output logic ps2_clk_fall,
  output logic data_sample
);

  // Two-flop synchronizers for both keyboard lines
  logic [1:0] clk_sync;
  logic [1:0] dat_sync;
  // Previous synchronized clock level for edge detection
  logic       clk_last;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      // Idle PS/2 bus reads high on both lines
      clk_sync     <= 2'b11;
      dat_sync     <= 2'b11;
      clk_last     <= 1'b1;
      ps2_clk_rise <= 1'b0;
      ps2_clk_fall <= 1'b0;
      data_sample  <= 1'b1;
    end
    else
    begin
      clk_sync <= {clk_sync[0], ps2_clk};
      dat_sync <= {dat_sync[0], ps2_dat};
      clk_last <= clk_sync[1];

      // Edge pulses are registered, three clocks after the pin edge
      ps2_clk_rise <= clk_sync[1] & ~clk_last;
      ps2_clk_fall <= ~clk_sync[1] & clk_last;

      // Extra stage keeps data in step with the edge pulses
      data_sample <= dat_sync[1];
    end
  end

endmodule

`default_nettype wire

//--- src/ps2_kbd_pkg.sv
`default_nettype none

package ps2_kbd_pkg;

  // One byte as it comes off the PS/2 data line
  typedef logic [7:0] scan_byte_t;

  // Keys followed by the tracker
  localparam int key_count = 10;

  // Bit order: left, right, up, down, w, a, s, d, space, enter
  typedef logic [key_count-1:0] key_vec_t;

  // Scan Code Set 2 codes, indexed like key_vec_t
  // Arrow codes only mean arrows after an E0 prefix, but the
  // tracker does not tell them apart from the keypad keys
  localparam scan_byte_t key_code_table [key_count] = '{
    8'h6B,  // left
    8'h74,  // right
    8'h75,  // up
    8'h72,  // down
    8'h1D,  // w
    8'h1C,  // a
    8'h1B,  // s
    8'h23,  // d
    8'h29,  // space
    8'h5A   // enter
  };

  // Prefix bytes
  localparam scan_byte_t code_extended = 8'hE0;
  localparam scan_byte_t code_break    = 8'hF0;

  // Payload bits between start and parity
  localparam int data_bits = 8;

  // Receiver FSM
  typedef enum logic [1:0] {
    rx_idle,
    rx_data_in,
    rx_parity_in,
    rx_stop_in
  } rx_state_t;

  // What the decoder expects the next key code to mean
  typedef enum logic [1:0] {
    pfx_make,
    pfx_break,
    pfx_ext_make,
    pfx_ext_break
  } prefix_state_t;

endpackage

`default_nettype wire
